// ==== rtl/sram_tester_defs.svh ====
`ifndef SRAM_TESTER_DEFS_SVH
`define SRAM_TESTER_DEFS_SVH

// word address width of the SRAM
`define SRAM_ADDR_BITS 6

// data word width
`define SRAM_DATA_BITS 16

// expected FIFO holds 2**N words
`define EXP_FIFO_DEPTH_LOG2 2

// cycles the strobes stay active per access
`define SRAM_WAIT_CYCLES 2

// number of data patterns per full test
`define PATTERN_COUNT 5

`endif

// ==== rtl/sram_types_pkg.sv ====
`default_nettype none

`include "sram_tester_defs.svh"

package sram_types_pkg;

  // word address on the SRAM
  typedef logic [`SRAM_ADDR_BITS-1:0] sram_addr_t;

  // one data word, always written whole
  typedef logic [`SRAM_DATA_BITS-1:0] sram_data_t;

  // FIFO pointer, top bit is the wrap bit
  typedef logic [`EXP_FIFO_DEPTH_LOG2:0] fifo_ptr_t;

endpackage

`default_nettype wire

// ==== rtl/tester_ctrl_pkg.sv ====
`default_nettype none

package tester_ctrl_pkg;

  typedef enum logic [2:0] {
    st_start,
    st_write,
    st_read,
    st_next_pattern,
    st_done,
    st_halt
  } tester_state_t;

  // order here is the order the tester runs them
  typedef enum logic [2:0] {
    pat_zeros,
    pat_ones,
    pat_checker,
    pat_inv_checker,
    pat_addr
  } pattern_kind_t;

  typedef enum logic [1:0] {
    ph_idle,
    ph_write,
    ph_read,
    ph_respond
  } ctrl_phase_t;

endpackage

`default_nettype wire

// ==== rtl/addr_iter.sv ====
`default_nettype none

module addr_iter
  import sram_types_pkg::*;
(
  input  wire        clk,
  input  wire        reset,
  input  wire        step,
  input  wire        clear,
  output sram_addr_t addr,
  output logic       last
);

  // highest address closes a sweep
  assign last = (addr == '1);

  always_ff @(posedge clk) begin
    if (reset) begin
      addr <= '0;
    end else if (clear) begin
      addr <= '0;
    end else if (step) begin
      // wrap back for the next sweep
      if (last) begin
        addr <= '0;
      end else begin
        addr <= addr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pattern_gen.sv ====
`default_nettype none

`include "sram_tester_defs.svh"

module pattern_gen
  import sram_types_pkg::*;
  import tester_ctrl_pkg::*;
(
  input  wire           clk,
  input  wire           reset,
  input  wire           step,
  input  wire           restart,
  input  wire sram_addr_t addr,
  output sram_data_t    pattern_data,
  output pattern_kind_t kind,
  output logic          last
);

  localparam pattern_kind_t last_kind = pattern_kind_t'(`PATTERN_COUNT - 1);

  assign last = (kind == last_kind);

  always_ff @(posedge clk) begin
    if (reset) begin
      kind <= pat_zeros;
    end else if (restart) begin
      kind <= pat_zeros;
    end else if (step) begin
      if (last) begin
        kind <= pat_zeros;
      end else begin
        kind <= pattern_kind_t'(kind + 3'd1);
      end
    end
  end

  // data word for the current kind
  always_comb begin
    case (kind)
      pat_zeros: begin
        pattern_data = '0;
      end
      pat_ones: begin
        pattern_data = '1;
      end
      pat_checker: begin
        pattern_data = {(`SRAM_DATA_BITS / 2){2'b10}};
      end
      pat_inv_checker: begin
        pattern_data = {(`SRAM_DATA_BITS / 2){2'b01}};
      end
      pat_addr: begin
        // address zero-extended into the word
        pattern_data = sram_data_t'(addr);
      end
      default: begin
        pattern_data = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/expected_fifo.sv ====
`default_nettype none

`include "sram_tester_defs.svh"

module expected_fifo
  import sram_types_pkg::*;
(
  input  wire             clk,
  input  wire             reset,
  input  wire             push,
  input  wire sram_data_t push_data,
  input  wire             pop,
  output sram_data_t      pop_data,
  output logic            full,
  output logic            empty
);

  localparam int depth = 1 << `EXP_FIFO_DEPTH_LOG2;

  sram_data_t mem [depth];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  logic [`EXP_FIFO_DEPTH_LOG2-1:0] wr_idx;
  logic [`EXP_FIFO_DEPTH_LOG2-1:0] rd_idx;

  assign wr_idx = wr_ptr[`EXP_FIFO_DEPTH_LOG2-1:0];
  assign rd_idx = rd_ptr[`EXP_FIFO_DEPTH_LOG2-1:0];

  // same index, different lap means full
  assign empty = (wr_ptr == rd_ptr);
  assign full = (wr_ptr[`EXP_FIFO_DEPTH_LOG2] != rd_ptr[`EXP_FIFO_DEPTH_LOG2]) &&
                (wr_idx == rd_idx);

  // head word is always on the output
  assign pop_data = mem[rd_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push && !full) begin
      mem[wr_idx] <= push_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sram_ctrl.sv ====
`default_nettype none

`include "sram_tester_defs.svh"

module sram_ctrl
  import sram_types_pkg::*;
  import tester_ctrl_pkg::*;
(
  input  wire             clk,
  input  wire             reset,
  input  wire             cmd_valid,
  input  wire             cmd_write,
  input  wire sram_addr_t cmd_addr,
  input  wire sram_data_t cmd_wdata,
  input  wire             rsp_ready,
  output logic            cmd_ready,
  output logic            rsp_valid,
  output sram_data_t      rsp_data,
  output sram_addr_t      sram_addr,
  output logic            sram_ce_n,
  output logic            sram_oe_n,
  output logic            sram_we_n,
  inout  wire sram_data_t sram_data
);

  localparam int wait_bits = $clog2(`SRAM_WAIT_CYCLES + 1);

  ctrl_phase_t phase;
  logic [wait_bits-1:0] wait_cnt;
  logic wait_last;
  logic cmd_take;
  sram_data_t wdata_q;

  assign cmd_ready = (phase == ph_idle);
  assign rsp_valid = (phase == ph_respond);
  assign cmd_take  = cmd_valid && cmd_ready;
  assign wait_last = (wait_cnt == '0);

  // strobes decode straight from the phase
  assign sram_ce_n = !((phase == ph_write) || (phase == ph_read));
  assign sram_we_n = (phase != ph_write);
  assign sram_oe_n = (phase != ph_read);

  // bus only driven during the write strobe
  assign sram_data = sram_we_n ? 'z : wdata_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase    <= ph_idle;
      wait_cnt <= '0;
    end else begin
      case (phase)
        ph_idle: begin
          if (cmd_take) begin
            phase    <= cmd_write ? ph_write : ph_read;
            wait_cnt <= wait_bits'(`SRAM_WAIT_CYCLES - 1);
          end
        end
        ph_write: begin
          if (wait_last) begin
            phase <= ph_idle;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        ph_read: begin
          if (wait_last) begin
            phase <= ph_respond;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        ph_respond: begin
          // hold the word until it is taken
          if (rsp_ready) begin
            phase <= ph_idle;
          end
        end
        default: begin
          phase <= ph_idle;
        end
      endcase
    end
  end

  // command latch and read sample
  always_ff @(posedge clk) begin
    if (cmd_take) begin
      sram_addr <= cmd_addr;
      wdata_q   <= cmd_wdata;
    end
    if ((phase == ph_read) && wait_last) begin
      rsp_data <= sram_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tester_fsm.sv ====
`default_nettype none

module tester_fsm
  import sram_types_pkg::*;
  import tester_ctrl_pkg::*;
(
  input  wire             clk,
  input  wire             reset,
  input  wire             cmd_ready,
  input  wire             rsp_valid,
  input  wire sram_data_t rsp_data,
  input  wire sram_addr_t addr,
  input  wire             addr_last,
  input  wire sram_data_t pattern_data,
  input  wire             pattern_last,
  input  wire             fifo_full,
  input  wire sram_data_t expected,
  output logic            cmd_valid,
  output logic            cmd_write,
  output sram_addr_t      cmd_addr,
  output sram_data_t      cmd_wdata,
  output logic            rsp_ready,
  output logic            addr_step,
  output logic            addr_clear,
  output logic            pattern_step,
  output logic            pattern_restart,
  output logic            fifo_push,
  output logic            fifo_pop,
  output logic            test_done,
  output logic            test_pass,
  output sram_data_t      read_data,
  output sram_data_t      expected_data
);

  tester_state_t state;
  logic cmd_fire;
  logic rsp_fire;
  logic mismatch;
  logic issue;
  // last read of the sweep is out, wait for its response
  logic sweep_end;

  assign cmd_fire = cmd_valid && cmd_ready;
  assign rsp_fire = rsp_valid && rsp_ready;
  assign mismatch = rsp_fire && (rsp_data != expected);

  // one command at a time, reads gated by FIFO space
  assign issue = !cmd_valid && !mismatch &&
                 ((state == st_write) ||
                  ((state == st_read) && !fifo_full && !sweep_end));

  assign addr_step       = cmd_fire;
  assign addr_clear      = (state == st_start);
  assign pattern_step    = (state == st_next_pattern);
  assign pattern_restart = (state == st_done);
  assign fifo_push       = cmd_fire && !cmd_write;
  assign fifo_pop        = rsp_fire;
  assign test_done       = (state == st_done);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_start;
      cmd_valid <= 1'b0;
      sweep_end <= 1'b0;
      test_pass <= 1'b1;
      rsp_ready <= 1'b0;
    end else begin
      rsp_ready <= 1'b1;
      if (cmd_fire) begin
        cmd_valid <= 1'b0;
      end else if (issue) begin
        cmd_valid <= 1'b1;
      end
      if (mismatch) begin
        // sticky fail, the tester stops here
        test_pass <= 1'b0;
        cmd_valid <= 1'b0;
        state     <= st_halt;
      end else begin
        case (state)
          st_start: begin
            state <= st_write;
          end
          st_write: begin
            if (cmd_fire && addr_last) begin
              state <= st_read;
            end
          end
          st_read: begin
            if (cmd_fire && addr_last) begin
              sweep_end <= 1'b1;
            end
            if (sweep_end && rsp_fire) begin
              sweep_end <= 1'b0;
              state     <= pattern_last ? st_done : st_next_pattern;
            end
          end
          st_next_pattern: begin
            state <= st_write;
          end
          st_done: begin
            state <= st_write;
          end
          default: begin
            state <= st_halt;
          end
        endcase
      end
    end
  end

  // command fields latched at issue, held until transfer
  always_ff @(posedge clk) begin
    if (issue) begin
      cmd_write <= (state == st_write);
      cmd_addr  <= addr;
      cmd_wdata <= pattern_data;
    end
  end

  // last compared pair for debug
  always_ff @(posedge clk) begin
    if (reset) begin
      read_data     <= '0;
      expected_data <= '0;
    end else if (rsp_fire) begin
      read_data     <= rsp_data;
      expected_data <= expected;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sram_tester.sv ====
`default_nettype none

module sram_tester
  import sram_types_pkg::*;
  import tester_ctrl_pkg::*;
(
  input  wire             clk,
  input  wire             reset,
  output logic            test_done,
  output logic            test_pass,
  output pattern_kind_t   pattern_kind,
  output sram_data_t      read_data,
  output sram_data_t      expected_data,
  output sram_addr_t      iter_addr,
  output sram_addr_t      sram_addr,
  output logic            sram_ce_n,
  output logic            sram_oe_n,
  output logic            sram_we_n,
  inout  wire sram_data_t sram_data
);

  // command channel
  logic cmd_valid;
  logic cmd_ready;
  logic cmd_write;
  sram_addr_t cmd_addr;
  sram_data_t cmd_wdata;

  // read response channel
  logic rsp_valid;
  logic rsp_ready;
  sram_data_t rsp_data;

  logic addr_step;
  logic addr_clear;
  logic addr_last;
  logic pattern_step;
  logic pattern_restart;
  logic pattern_last;
  sram_data_t pattern_data;
  logic fifo_push;
  logic fifo_pop;
  logic fifo_full;
  sram_data_t fifo_head;

  tester_fsm fsm_i (
    .clk            (clk),
    .reset          (reset),
    .cmd_ready      (cmd_ready),
    .rsp_valid      (rsp_valid),
    .rsp_data       (rsp_data),
    .addr           (iter_addr),
    .addr_last      (addr_last),
    .pattern_data   (pattern_data),
    .pattern_last   (pattern_last),
    .fifo_full      (fifo_full),
    .expected       (fifo_head),
    .cmd_valid      (cmd_valid),
    .cmd_write      (cmd_write),
    .cmd_addr       (cmd_addr),
    .cmd_wdata      (cmd_wdata),
    .rsp_ready      (rsp_ready),
    .addr_step      (addr_step),
    .addr_clear     (addr_clear),
    .pattern_step   (pattern_step),
    .pattern_restart(pattern_restart),
    .fifo_push      (fifo_push),
    .fifo_pop       (fifo_pop),
    .test_done      (test_done),
    .test_pass      (test_pass),
    .read_data      (read_data),
    .expected_data  (expected_data)
  );

  addr_iter iter_i (
    .clk  (clk),
    .reset(reset),
    .step (addr_step),
    .clear(addr_clear),
    .addr (iter_addr),
    .last (addr_last)
  );

  pattern_gen pattern_i (
    .clk         (clk),
    .reset       (reset),
    .step        (pattern_step),
    .restart     (pattern_restart),
    .addr        (iter_addr),
    .pattern_data(pattern_data),
    .kind        (pattern_kind),
    .last        (pattern_last)
  );

  // read commands carry their expected word in cmd_wdata
  expected_fifo fifo_i (
    .clk      (clk),
    .reset    (reset),
    .push     (fifo_push),
    .push_data(cmd_wdata),
    .pop      (fifo_pop),
    .pop_data (fifo_head),
    .full     (fifo_full),
    .empty    ()
  );

  sram_ctrl ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .cmd_valid(cmd_valid),
    .cmd_write(cmd_write),
    .cmd_addr (cmd_addr),
    .cmd_wdata(cmd_wdata),
    .rsp_ready(rsp_ready),
    .cmd_ready(cmd_ready),
    .rsp_valid(rsp_valid),
    .rsp_data (rsp_data),
    .sram_addr(sram_addr),
    .sram_ce_n(sram_ce_n),
    .sram_oe_n(sram_oe_n),
    .sram_we_n(sram_we_n),
    .sram_data(sram_data)
  );

endmodule

`default_nettype wire

// ==== sim/sram_model.sv ====
`default_nettype none

`include "sram_tester_defs.svh"

module sram_model
  import sram_types_pkg::*;
(
  input  wire                               ce_n,
  input  wire                               oe_n,
  input  wire                               we_n,
  input  wire sram_addr_t                   addr,
  inout  wire sram_data_t                   data,
  input  wire                               fault_enable,
  input  wire sram_addr_t                   fault_addr,
  input  wire [$clog2(`SRAM_DATA_BITS)-1:0] fault_bit
);

  sram_data_t mem [1 << `SRAM_ADDR_BITS];
  sram_data_t stuck_mask;
  logic drive;

  // stuck-at-one cell, seen on every read of that address
  assign stuck_mask = (fault_enable && (addr == fault_addr)) ?
                      (sram_data_t'(1) << fault_bit) : '0;
  assign drive = !ce_n && !oe_n && we_n;
  assign data = drive ? (mem[addr] | stuck_mask) : 'z;

  // word taken once address and data have settled under the strobe
  always @(negedge we_n) begin
    #2;
    if (!ce_n && !we_n) begin
      mem[addr] = data;
    end
  end

endmodule

`default_nettype wire

// ==== sim/sram_tester_sva.sv ====
`default_nettype none

module sram_tester_sva
  import sram_types_pkg::*;
(
  input wire             clk,
  input wire             reset,
  input wire             cmd_valid,
  input wire             cmd_ready,
  input wire             cmd_write,
  input wire sram_addr_t cmd_addr,
  input wire sram_data_t cmd_wdata,
  input wire             rsp_valid,
  input wire             rsp_ready,
  input wire             sram_oe_n,
  input wire             sram_we_n
);

  // never drive and read the bus at once
  strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(!sram_we_n && !sram_oe_n))
    else $error("sram_we_n and sram_oe_n low together");

  cmd_stable: assert property (@(posedge clk) disable iff (reset)
    cmd_valid && !cmd_ready |=>
      $stable(cmd_write) && $stable(cmd_addr) && $stable(cmd_wdata))
    else $error("command fields changed while waiting for cmd_ready");

  // response held until taken
  rsp_hold: assert property (@(posedge clk) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid)
    else $error("rsp_valid dropped before rsp_ready");

endmodule

bind sram_ctrl sram_tester_sva sva_i (
  .clk      (clk),
  .reset    (reset),
  .cmd_valid(cmd_valid),
  .cmd_ready(cmd_ready),
  .cmd_write(cmd_write),
  .cmd_addr (cmd_addr),
  .cmd_wdata(cmd_wdata),
  .rsp_valid(rsp_valid),
  .rsp_ready(rsp_ready),
  .sram_oe_n(sram_oe_n),
  .sram_we_n(sram_we_n)
);

`default_nettype wire

// ==== sim/sram_tester_tb.sv ====
`default_nettype none

`include "sram_tester_defs.svh"

module sram_tester_tb
  import sram_types_pkg::*;
  import tester_ctrl_pkg::*;
();

  localparam int bit_sel_bits = $clog2(`SRAM_DATA_BITS);
  // one full test is about 5 x 64 x 8 cycles, the run covers three with margin
  localparam int cycle_limit = 20000;
  localparam int halt_cycles = 200;

  logic clk;
  logic reset;
  logic test_done;
  logic test_pass;
  pattern_kind_t pattern_kind;
  sram_data_t read_data;
  sram_data_t expected_data;
  sram_addr_t iter_addr;
  sram_addr_t sram_addr;
  logic sram_ce_n;
  logic sram_oe_n;
  logic sram_we_n;
  wire sram_data_t sram_data;

  logic fault_enable;
  sram_addr_t fault_addr;
  logic [bit_sel_bits-1:0] fault_bit;

  int error_count;
  int check_count;
  int cycle_count;
  logic run_complete;
  logic [31:0] lfsr_state;

  // bus and pattern tracking
  pattern_kind_t kind_order [`PATTERN_COUNT] =
    '{pat_zeros, pat_ones, pat_checker, pat_inv_checker, pat_addr};
  int kind_idx;
  pattern_kind_t kind_prev;
  logic oe_prev;
  int read_count;
  logic check_pending;
  sram_data_t strobe_exp;
  sram_data_t pending_exp;

  sram_tester dut_i (
    .clk          (clk),
    .reset        (reset),
    .test_done    (test_done),
    .test_pass    (test_pass),
    .pattern_kind (pattern_kind),
    .read_data    (read_data),
    .expected_data(expected_data),
    .iter_addr    (iter_addr),
    .sram_addr    (sram_addr),
    .sram_ce_n    (sram_ce_n),
    .sram_oe_n    (sram_oe_n),
    .sram_we_n    (sram_we_n),
    .sram_data    (sram_data)
  );

  sram_model model_i (
    .ce_n        (sram_ce_n),
    .oe_n        (sram_oe_n),
    .we_n        (sram_we_n),
    .addr        (sram_addr),
    .data        (sram_data),
    .fault_enable(fault_enable),
    .fault_addr  (fault_addr),
    .fault_bit   (fault_bit)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      run_complete = 1'b1;
      $display("timeout: tester did not finish within %0d cycles", cycle_limit);
      $display("checks: %0d  errors: %0d", check_count, error_count);
      $display("tests failed");
      $finish;
    end
  end

  // run stopped by a failing assertion
  final begin
    if (!run_complete) begin
      $display("tests failed");
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  task automatic lfsr_take(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  // expected word per pattern kind
  function automatic sram_data_t pattern_word(input pattern_kind_t kind,
                                              input sram_addr_t addr);
    case (kind)
      pat_zeros: begin
        return 16'h0000;
      end
      pat_ones: begin
        return 16'hffff;
      end
      pat_checker: begin
        return 16'haaaa;
      end
      pat_inv_checker: begin
        return 16'h5555;
      end
      default: begin
        return sram_data_t'(addr);
      end
    endcase
  endfunction

  task automatic check_data(input sram_data_t got, input sram_data_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input sram_addr_t got, input sram_addr_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_kind(input pattern_kind_t got, input pattern_kind_t exp,
                            input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s is %0d (%s), expected %s", $time, what, got,
               got.name(), exp.name());
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic apply_reset(input logic fault_on, input sram_addr_t f_addr,
                             input logic [bit_sel_bits-1:0] f_bit);
    @(posedge clk);
    #1;
    reset = 1'b1;
    fault_enable = fault_on;
    fault_addr = f_addr;
    fault_bit = f_bit;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_bit(test_pass, 1'b1, "test_pass after reset");
    check_bit(test_done, 1'b0, "test_done after reset");
    check_bit(sram_ce_n, 1'b1, "sram_ce_n after reset");
    check_bit(sram_oe_n, 1'b1, "sram_oe_n after reset");
    check_bit(sram_we_n, 1'b1, "sram_we_n after reset");
    check_kind(pattern_kind, pat_zeros, "pattern_kind after reset");
    kind_idx = 0;
    kind_prev = pat_zeros;
    oe_prev = 1'b1;
    read_count = 0;
    check_pending = 1'b0;
  endtask

  task automatic track_kind();
    if (pattern_kind != kind_prev) begin
      if (kind_idx < `PATTERN_COUNT - 1) begin
        kind_idx++;
      end
      check_kind(pattern_kind, kind_order[kind_idx], "pattern_kind order");
    end
    kind_prev = pattern_kind;
  endtask

  // read address counted from zero in each read sweep
  task automatic track_reads(input logic compare);
    if (check_pending && compare) begin
      check_data(expected_data, pending_exp, "expected_data");
      check_data(read_data, pending_exp, "read_data");
    end
    check_pending = 1'b0;
    if (!sram_we_n) begin
      read_count = 0;
    end
    if (oe_prev && !sram_oe_n) begin
      check_addr(sram_addr, sram_addr_t'(read_count), "sram_addr on read strobe");
      // iterator already stepped past the accepted read
      check_addr(iter_addr, sram_addr_t'(read_count + 1), "iter_addr on read strobe");
      strobe_exp = pattern_word(kind_order[kind_idx], sram_addr_t'(read_count));
      read_count++;
    end
    // response cycle, compared pair updates at its end
    if (!oe_prev && sram_oe_n) begin
      check_pending = 1'b1;
      pending_exp = strobe_exp;
    end
    oe_prev = sram_oe_n;
  endtask

  task automatic clean_pass_test();
    apply_reset(1'b0, '0, '0);
    do begin
      @(negedge clk);
      check_bit(test_pass, 1'b1, "test_pass before test_done");
      track_kind();
      track_reads(1'b1);
    end while (!test_done);
    check_kind(pattern_kind, pat_addr, "pattern_kind at test_done");
    @(negedge clk);
    check_bit(test_done, 1'b0, "test_done one cycle after pulse");
    check_kind(pattern_kind, pat_zeros, "pattern_kind after test_done");
  endtask

  task automatic stuck_bit_test();
    logic [31:0] bits;
    sram_addr_t f_addr;
    logic [bit_sel_bits-1:0] f_bit;
    @(posedge clk);
    #1;
    lfsr_take(`SRAM_ADDR_BITS, bits);
    f_addr = sram_addr_t'(bits);
    lfsr_take(bit_sel_bits, bits);
    f_bit = bits[bit_sel_bits-1:0];
    apply_reset(1'b1, f_addr, f_bit);
    do begin
      @(negedge clk);
      check_bit(test_done, 1'b0, "test_done with stuck bit");
      track_reads(1'b0);
    end while (test_pass);
    check_data(read_data ^ expected_data, sram_data_t'(1) << f_bit,
               "read_data xor expected_data");
    check_data(expected_data, pattern_word(pat_zeros, f_addr), "expected_data at fail");
    check_addr(sram_addr_t'(read_count - 1), f_addr, "failing read address");
    // halted, no strobes and no done
    repeat (halt_cycles) begin
      @(negedge clk);
      check_bit(sram_ce_n, 1'b1, "sram_ce_n in halt");
      check_bit(test_done, 1'b0, "test_done in halt");
      check_bit(test_pass, 1'b0, "test_pass in halt");
    end
  endtask

  task automatic restart_test();
    check_bit(test_pass, 1'b0, "test_pass before restart");
    clean_pass_test();
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    fault_enable = 1'b0;
    fault_addr = '0;
    fault_bit = '0;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    run_complete = 1'b0;
    lfsr_state = 32'he453;
    clean_pass_test();
    stuck_bit_test();
    restart_test();
    run_complete = 1'b1;
    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
rtl/sram_types_pkg.sv
rtl/tester_ctrl_pkg.sv
rtl/addr_iter.sv
rtl/pattern_gen.sv
rtl/expected_fifo.sv
rtl/sram_ctrl.sv
rtl/tester_fsm.sv
rtl/sram_tester.sv
sim/sram_model.sv
sim/sram_tester_sva.sv
sim/sram_tester_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module sram_tester_tb -f sources.f -o sram_tester_sim \
  && ./obj_dir/sram_tester_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qx "all tests passed" sim.log && exit 0 || exit 1
